// File: design/debug_report_pkg.sv
package debug_report_pkg;

    // ========================================================
    // Bit timing
    // ========================================================

    localparam int unsigned CLK_FREQ_HZ  = 25_000_000;
    localparam int unsigned BAUD_RATE    = 115_200;
    // 25 MHz / 115200 truncates to 217 clocks
    localparam int unsigned CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;
    // Width of the bit-period counter
    localparam int unsigned BIT_CNT_W    = $clog2(CLKS_PER_BIT);

    // ========================================================
    // Report line layout
    // ========================================================

    // 49 printable characters plus CR and LF
    localparam int unsigned MSG_LEN = 51;
    // Character index width
    localparam int unsigned IDX_W   = $clog2(MSG_LEN);

    // Field widths
    localparam int unsigned FRAME_W = 16;
    localparam int unsigned PC_W    = 12;
    localparam int unsigned COUNT_W = 16;
    localparam int unsigned COORD_W = 10;

    // Decimal fields clip here
    localparam int unsigned PV_MAX    = 9999;
    localparam int unsigned COORD_MAX = 999;

    // ========================================================
    // Status and snapshot types
    // ========================================================

    // CPU debug status, sampled once per frame
    typedef struct packed {
        logic [PC_W-1:0]    pc;
        logic [COUNT_W-1:0] instr_count;
        logic [COUNT_W-1:0] iot_count;     // Display instructions
        logic               running;
    } cpu_status_t;

    // Pixel coordinates
    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
    } pixel_pos_t;

    // Everything one report line prints
    typedef struct packed {
        logic [FRAME_W-1:0] frame;
        cpu_status_t        cpu;
        logic [COUNT_W-1:0] pv_count;
        pixel_pos_t         pos;
    } frame_snapshot_t;

    // ========================================================
    // Digit to ASCII
    // ========================================================

    // Upper-case hex, 0-9 then A-F
    function automatic logic [7:0] hex_ascii(input logic [3:0] digit);
        if (digit < 4'd10) begin
            return 8'h30 + {4'h0, digit};
        end
        return 8'h37 + {4'h0, digit};
    endfunction

    // Decimal digit, caller keeps it in 0-9
    function automatic logic [7:0] dec_ascii(input logic [3:0] digit);
        return 8'h30 + {4'h0, digit};
    endfunction

endpackage

// File: design/uart_tx.sv
`timescale 1ns/100ps

module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tx_byte,
    input  logic       tx_send,
    output logic       txd,
    output logic       busy
);

    import debug_report_pkg::*;

    // ========================================================
    // State and counters
    // ========================================================

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t            state;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [2:0]           bit_idx;
    logic [7:0]           shift_q;
    logic                 bit_done;

    // Last clock of the current bit period
    assign bit_done = (bit_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

    // ========================================================
    // Bit sequencer
    // ========================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            txd     <= 1'b1;
            busy    <= 1'b0;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else begin
            // Period counter runs in every state but idle
            if (state == TX_IDLE || bit_done) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end

            case (state)
                TX_IDLE: begin
                    if (tx_send) begin
                        txd   <= 1'b0;    // Start bit
                        busy  <= 1'b1;
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        // First data bit, LSB first
                        txd     <= shift_q[0];
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        if (bit_idx == 3'd7) begin
                            txd   <= 1'b1;  // Stop bit
                            state <= TX_STOP;
                        end else begin
                            txd     <= shift_q[0];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                TX_STOP: begin
                    // Line back to idle level already
                    if (bit_done) begin
                        busy  <= 1'b0;
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Byte shifter, bit 0 is always the next bit out
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_send) begin
            shift_q <= tx_byte;
        end else if ((state == TX_START || state == TX_DATA) && bit_done) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    // Sender must respect busy
    assert property (@(posedge clk) disable iff (!rst_n) tx_send |-> !busy);

endmodule

// File: design/frame_snapshot.sv
`timescale 1ns/100ps

module frame_snapshot (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              frame_tick,
    input  logic                              pixel_valid,
    input  debug_report_pkg::cpu_status_t     cpu,
    input  debug_report_pkg::pixel_pos_t      pos,
    output debug_report_pkg::frame_snapshot_t snap,
    output logic                              snap_valid
);

    import debug_report_pkg::*;

    // ========================================================
    // Frame and pixel counters
    // ========================================================

    logic [FRAME_W-1:0] frame_cnt;
    logic [COUNT_W-1:0] pv_cnt;
    logic [COUNT_W-1:0] pv_next;
    logic [COORD_W-1:0] x_sat;
    logic [COORD_W-1:0] y_sat;

    // Count including this cycle, stuck at PV_MAX
    assign pv_next = (pixel_valid && pv_cnt != COUNT_W'(PV_MAX)) ?
                     pv_cnt + 1'b1 : pv_cnt;

    // Coordinates clipped to three digits
    assign x_sat = (pos.x > COORD_W'(COORD_MAX)) ? COORD_W'(COORD_MAX) : pos.x;
    assign y_sat = (pos.y > COORD_W'(COORD_MAX)) ? COORD_W'(COORD_MAX) : pos.y;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_cnt  <= '0;
            pv_cnt     <= '0;
            snap_valid <= 1'b0;
        end else begin
            snap_valid <= frame_tick;
            if (frame_tick) begin
                frame_cnt <= frame_cnt + 1'b1;
                // A pulse in the tick cycle belongs to the closing frame
                pv_cnt    <= '0;
            end else begin
                pv_cnt <= pv_next;
            end
        end
    end

    // ========================================================
    // Snapshot register
    // ========================================================

    always_ff @(posedge clk) begin
        if (frame_tick) begin
            snap.frame    <= frame_cnt;   // Ticks seen before this one
            snap.cpu      <= cpu;
            snap.pv_count <= pv_next;
            snap.pos.x    <= x_sat;
            snap.pos.y    <= y_sat;
        end
    end

endmodule

// File: design/report_formatter.sv
`timescale 1ns/100ps

module report_formatter (
    input  logic                              clk,
    input  logic                              rst_n,
    input  debug_report_pkg::frame_snapshot_t snap,
    input  logic                              snap_valid,
    input  logic                              busy,
    output logic [7:0]                        tx_byte,
    output logic                              tx_send
);

    import debug_report_pkg::*;

    // ========================================================
    // State
    // ========================================================

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_WAIT_BUSY,
        ST_DRAIN
    } fmt_state_t;

    fmt_state_t      state;
    logic [IDX_W-1:0] char_idx;
    frame_snapshot_t snap_q;
    logic [7:0]      cur_char;

    // Decimal digits of the held snapshot
    logic [3:0] pv_d3, pv_d2, pv_d1, pv_d0;
    logic [3:0] x_d2, x_d1, x_d0;
    logic [3:0] y_d2, y_d1, y_d0;

    // One decimal digit at a given weight
    function automatic logic [3:0] dec_digit(input logic [COUNT_W-1:0] value,
                                             input logic [COUNT_W-1:0] weight);
        logic [COUNT_W-1:0] q;
        q = (value / weight) % COUNT_W'(10);
        return q[3:0];
    endfunction

    assign pv_d3 = dec_digit(snap_q.pv_count, COUNT_W'(1000));
    assign pv_d2 = dec_digit(snap_q.pv_count, COUNT_W'(100));
    assign pv_d1 = dec_digit(snap_q.pv_count, COUNT_W'(10));
    assign pv_d0 = dec_digit(snap_q.pv_count, COUNT_W'(1));

    assign x_d2 = dec_digit(COUNT_W'(snap_q.pos.x), COUNT_W'(100));
    assign x_d1 = dec_digit(COUNT_W'(snap_q.pos.x), COUNT_W'(10));
    assign x_d0 = dec_digit(COUNT_W'(snap_q.pos.x), COUNT_W'(1));

    assign y_d2 = dec_digit(COUNT_W'(snap_q.pos.y), COUNT_W'(100));
    assign y_d1 = dec_digit(COUNT_W'(snap_q.pos.y), COUNT_W'(10));
    assign y_d0 = dec_digit(COUNT_W'(snap_q.pos.y), COUNT_W'(1));

    // ========================================================
    // Character at the current index
    // ========================================================

    // "F:ffff PC:ppp I:iiii D:dddd V:vvvv X:xxx Y:yyy s " CR LF
    always_comb begin
        case (char_idx)
            6'd0:    cur_char = "F";
            6'd1:    cur_char = ":";
            6'd2:    cur_char = hex_ascii(snap_q.frame[15:12]);
            6'd3:    cur_char = hex_ascii(snap_q.frame[11:8]);
            6'd4:    cur_char = hex_ascii(snap_q.frame[7:4]);
            6'd5:    cur_char = hex_ascii(snap_q.frame[3:0]);
            6'd7:    cur_char = "P";
            6'd8:    cur_char = "C";
            6'd9:    cur_char = ":";
            6'd10:   cur_char = hex_ascii(snap_q.cpu.pc[11:8]);
            6'd11:   cur_char = hex_ascii(snap_q.cpu.pc[7:4]);
            6'd12:   cur_char = hex_ascii(snap_q.cpu.pc[3:0]);
            6'd14:   cur_char = "I";
            6'd15:   cur_char = ":";
            6'd16:   cur_char = hex_ascii(snap_q.cpu.instr_count[15:12]);
            6'd17:   cur_char = hex_ascii(snap_q.cpu.instr_count[11:8]);
            6'd18:   cur_char = hex_ascii(snap_q.cpu.instr_count[7:4]);
            6'd19:   cur_char = hex_ascii(snap_q.cpu.instr_count[3:0]);
            6'd21:   cur_char = "D";
            6'd22:   cur_char = ":";
            6'd23:   cur_char = hex_ascii(snap_q.cpu.iot_count[15:12]);
            6'd24:   cur_char = hex_ascii(snap_q.cpu.iot_count[11:8]);
            6'd25:   cur_char = hex_ascii(snap_q.cpu.iot_count[7:4]);
            6'd26:   cur_char = hex_ascii(snap_q.cpu.iot_count[3:0]);
            6'd28:   cur_char = "V";
            6'd29:   cur_char = ":";
            6'd30:   cur_char = dec_ascii(pv_d3);
            6'd31:   cur_char = dec_ascii(pv_d2);
            6'd32:   cur_char = dec_ascii(pv_d1);
            6'd33:   cur_char = dec_ascii(pv_d0);
            6'd35:   cur_char = "X";
            6'd36:   cur_char = ":";
            6'd37:   cur_char = dec_ascii(x_d2);
            6'd38:   cur_char = dec_ascii(x_d1);
            6'd39:   cur_char = dec_ascii(x_d0);
            6'd41:   cur_char = "Y";
            6'd42:   cur_char = ":";
            6'd43:   cur_char = dec_ascii(y_d2);
            6'd44:   cur_char = dec_ascii(y_d1);
            6'd45:   cur_char = dec_ascii(y_d0);
            6'd47:   cur_char = snap_q.cpu.running ? "R" : ".";
            6'd49:   cur_char = 8'h0d;    // CR
            6'd50:   cur_char = 8'h0a;    // LF
            // Field separators
            default: cur_char = " ";
        endcase
    end

    // ========================================================
    // Send sequencer
    // ========================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            char_idx <= '0;
            tx_send  <= 1'b0;
        end else begin
            tx_send <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // New report only when nothing is in flight
                    if (snap_valid) begin
                        char_idx <= '0;
                        state    <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    if (!busy) begin
                        tx_send <= 1'b1;
                        state   <= ST_WAIT_BUSY;
                    end
                end
                ST_WAIT_BUSY: begin
                    // Byte accepted once busy goes high
                    if (busy) begin
                        if (char_idx == IDX_W'(MSG_LEN - 1)) begin
                            state <= ST_DRAIN;
                        end else begin
                            char_idx <= char_idx + 1'b1;
                            state    <= ST_SEND;
                        end
                    end
                end
                ST_DRAIN: begin
                    // LF still on the wire
                    if (!busy) begin
                        char_idx <= '0;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Held line values and outgoing byte
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && snap_valid) begin
            snap_q <= snap;
        end
        if (state == ST_SEND && !busy) begin
            tx_byte <= cur_char;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) char_idx < IDX_W'(MSG_LEN));

endmodule

// File: design/serial_debug_top.sv
`timescale 1ns/100ps

module serial_debug_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          frame_tick,
    input  logic                          pixel_valid,
    input  debug_report_pkg::cpu_status_t cpu,
    input  debug_report_pkg::pixel_pos_t  pos,
    output logic                          uart_txd
);

    import debug_report_pkg::*;

    // ========================================================
    // Internal links
    // ========================================================

    frame_snapshot_t snap;
    logic            snap_valid;
    logic [7:0]      tx_byte;
    logic            tx_send;
    logic            busy;

    // Per-frame capture
    frame_snapshot frame_snapshot_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_tick  (frame_tick),
        .pixel_valid (pixel_valid),
        .cpu         (cpu),
        .pos         (pos),
        .snap        (snap),
        .snap_valid  (snap_valid)
    );

    // Line builder
    report_formatter report_formatter_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .snap       (snap),
        .snap_valid (snap_valid),
        .busy       (busy),
        .tx_byte    (tx_byte),
        .tx_send    (tx_send)
    );

    // 8N1 serializer onto the pin
    uart_tx uart_tx_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .tx_byte (tx_byte),
        .tx_send (tx_send),
        .txd     (uart_txd),
        .busy    (busy)
    );

endmodule

// File: dv/uart_line_monitor.sv
`timescale 1ns/100ps

module uart_line_monitor (
    input  logic                 clk,
    input  logic                 rxd,
    output int                   byte_count,
    output int                   line_count,
    output int                   line_len,
    output int                   start_errors,
    output int                   stop_errors,
    output logic [8*64-1:0]      line_data
);

    import debug_report_pkg::*;

    localparam int MAX_LEN = 64;

    logic [8*MAX_LEN-1:0] cur_line;
    int                   cur_len;
    logic [7:0]           rx_byte;

    // ========================================================
    // 8N1 receiver sampling at mid-bit
    // ========================================================

    initial begin
        byte_count   = 0;
        line_count   = 0;
        line_len     = 0;
        start_errors = 0;
        stop_errors  = 0;
        line_data    = '0;
        cur_line     = '0;
        cur_len      = 0;
        rx_byte      = '0;
        forever begin
            @(negedge rxd);
            repeat (CLKS_PER_BIT / 2) @(posedge clk);
            if (rxd !== 1'b0) begin
                start_errors++;
                $display("Monitor at %0t: start bit did not hold low", $time);
                continue;
            end
            // Data bits with the LSB first
            for (int b = 0; b < 8; b++) begin
                repeat (CLKS_PER_BIT) @(posedge clk);
                rx_byte[b] = rxd;
            end
            repeat (CLKS_PER_BIT) @(posedge clk);
            if (rxd !== 1'b1) begin
                stop_errors++;
                $display("Monitor at %0t: byte %h has no valid stop bit", $time, rx_byte);
            end
            byte_count++;
            if (cur_len < MAX_LEN) begin
                cur_line[8*cur_len +: 8] = rx_byte;
            end
            cur_len++;
            // LF closes a line
            if (rx_byte == 8'h0a) begin
                line_data = cur_line;
                line_len  = cur_len;
                line_count++;
                cur_line  = '0;
                cur_len   = 0;
            end
        end
    end

endmodule

// File: dv/serial_debug_tb.sv
`timescale 1ns/100ps

module serial_debug_tb;

    import debug_report_pkg::*;

    // ========================================================
    // Run limits
    // ========================================================

    localparam int N_LINES      = 7;
    localparam int LINE_NS      = MSG_LEN * 10 * CLKS_PER_BIT * 10;
    // Longer than one whole byte on the pin
    localparam int QUIET_CYCLES = 12 * CLKS_PER_BIT;
    // Lines plus the quiet start and the long pulse frame
    localparam int WATCHDOG_NS  = 2 * N_LINES * LINE_NS + 2 * QUIET_CYCLES * 10 +
                                  2 * 12000 * 2 * 10;

    // What one accepted tick should print
    typedef struct packed {
        logic [FRAME_W-1:0] frame;
        cpu_status_t        cpu;
        logic [31:0]        pv;
        pixel_pos_t         pos;
    } report_exp_t;

    logic        clk;
    logic        rst_n;
    logic        frame_tick;
    logic        pixel_valid;
    cpu_status_t cpu;
    pixel_pos_t  pos;
    logic        uart_txd;

    int               byte_count;
    int               line_count;
    int               line_len;
    int               start_errors;
    int               stop_errors;
    logic [8*64-1:0]  line_data;

    int          seed = 32'he022;
    report_exp_t exp_q[$];
    int          frame_num;
    int          pv_acc;
    int          lines_expected;
    int          lines_checked;
    int          value_errors;
    int          other_errors;

    serial_debug_top serial_debug_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_tick  (frame_tick),
        .pixel_valid (pixel_valid),
        .cpu         (cpu),
        .pos         (pos),
        .uart_txd    (uart_txd)
    );

    uart_line_monitor line_mon (
        .clk          (clk),
        .rxd          (uart_txd),
        .byte_count   (byte_count),
        .line_count   (line_count),
        .line_len     (line_len),
        .start_errors (start_errors),
        .stop_errors  (stop_errors),
        .line_data    (line_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ========================================================
    // Reference line
    // ========================================================

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        if (n < 4'd10) begin
            return 8'd48 + {4'd0, n};
        end
        return 8'd55 + {4'd0, n};
    endfunction

    function automatic logic [7:0] dec_char(input int v, input int weight);
        int d;
        d = (v / weight) % 10;
        return 8'd48 + 8'(d);
    endfunction

    function automatic logic [8*MSG_LEN-1:0] ref_line(input report_exp_t e);
        logic [8*MSG_LEN-1:0] line;
        int pv_sat;
        int x_sat;
        int y_sat;
        pv_sat = (e.pv > 32'd9999) ? 9999 : int'(e.pv);
        x_sat  = (e.pos.x > 10'd999) ? 999 : int'(e.pos.x);
        y_sat  = (e.pos.y > 10'd999) ? 999 : int'(e.pos.y);
        line = {MSG_LEN{8'h20}};
        // Labels
        line[8*0 +: 8]  = "F";
        line[8*1 +: 8]  = ":";
        line[8*7 +: 8]  = "P";
        line[8*8 +: 8]  = "C";
        line[8*9 +: 8]  = ":";
        line[8*14 +: 8] = "I";
        line[8*15 +: 8] = ":";
        line[8*21 +: 8] = "D";
        line[8*22 +: 8] = ":";
        line[8*28 +: 8] = "V";
        line[8*29 +: 8] = ":";
        line[8*35 +: 8] = "X";
        line[8*36 +: 8] = ":";
        line[8*41 +: 8] = "Y";
        line[8*42 +: 8] = ":";
        // Hex fields with the most significant digit first
        for (int k = 0; k < 4; k++) begin
            line[8*(2+k) +: 8]  = hex_char(e.frame[4*(3-k) +: 4]);
            line[8*(16+k) +: 8] = hex_char(e.cpu.instr_count[4*(3-k) +: 4]);
            line[8*(23+k) +: 8] = hex_char(e.cpu.iot_count[4*(3-k) +: 4]);
        end
        for (int k = 0; k < 3; k++) begin
            line[8*(10+k) +: 8] = hex_char(e.cpu.pc[4*(2-k) +: 4]);
        end
        // Decimal fields
        line[8*30 +: 8] = dec_char(pv_sat, 1000);
        line[8*31 +: 8] = dec_char(pv_sat, 100);
        line[8*32 +: 8] = dec_char(pv_sat, 10);
        line[8*33 +: 8] = dec_char(pv_sat, 1);
        line[8*37 +: 8] = dec_char(x_sat, 100);
        line[8*38 +: 8] = dec_char(x_sat, 10);
        line[8*39 +: 8] = dec_char(x_sat, 1);
        line[8*43 +: 8] = dec_char(y_sat, 100);
        line[8*44 +: 8] = dec_char(y_sat, 10);
        line[8*45 +: 8] = dec_char(y_sat, 1);
        line[8*47 +: 8] = e.cpu.running ? "R" : ".";
        line[8*49 +: 8] = 8'h0d;
        line[8*50 +: 8] = 8'h0a;
        return line;
    endfunction

    // ========================================================
    // Stimulus helpers
    // ========================================================

    // One clock of input plus the model bookkeeping
    task automatic drive_cycle(input logic pv, input logic tick, input logic accept);
        @(posedge clk);
        #1;
        pixel_valid = pv;
        frame_tick  = tick;
        if (tick) begin
            if (accept) begin
                exp_q.push_back({FRAME_W'(frame_num), cpu, 32'(pv_acc + int'(pv)), pos});
                lines_expected++;
            end
            frame_num++;
            pv_acc = 0;
        end else begin
            pv_acc += int'(pv);
        end
    endtask

    task automatic randomize_status(input logic wide_pos, input logic running);
        logic [31:0] r;
        r = $random(seed);
        cpu.pc          = r[11:0];
        cpu.instr_count = r[31:16];
        r = $random(seed);
        cpu.iot_count   = r[15:0];
        cpu.running     = running;
        r = $random(seed);
        // Normal coordinates stay in three digits
        pos.x = wide_pos ? 10'd1023 : 10'(r[9:0] % 10'd1000);
        pos.y = wide_pos ? 10'd1000 : 10'(r[25:16] % 10'd1000);
    endtask

    // Pulses, then a tick that carries one more pulse
    task automatic run_frame(input int pulses, input logic accept);
        for (int i = 0; i < pulses; i++) begin
            drive_cycle(1'b1, 1'b0, 1'b0);
            drive_cycle(1'b0, 1'b0, 1'b0);
        end
        drive_cycle(1'b1, 1'b1, accept);
        drive_cycle(1'b0, 1'b0, 1'b0);
    endtask

    // Idle until the expected lines are in, then let the LF drain
    task automatic wait_lines();
        while (line_count < lines_expected) begin
            drive_cycle(1'b0, 1'b0, 1'b0);
        end
        repeat (CLKS_PER_BIT + 5) drive_cycle(1'b0, 1'b0, 1'b0);
    endtask

    // ========================================================
    // Line checker
    // ========================================================

    initial begin
        report_exp_t          e;
        logic [8*MSG_LEN-1:0] want;
        lines_checked = 0;
        forever begin
            @(negedge clk);
            if (line_count != lines_checked) begin
                lines_checked++;
                assert (line_len == MSG_LEN) else begin
                    value_errors++;
                    $display("ERROR: %0t line_len expected %0d got %0d",
                             $time, MSG_LEN, line_len);
                end
                assert (exp_q.size() > 0) else begin
                    other_errors++;
                    $display("A line arrived that no accepted frame_tick asked for");
                end
                if (exp_q.size() > 0) begin
                    e    = exp_q.pop_front();
                    want = ref_line(e);
                    for (int i = 0; i < MSG_LEN; i++) begin
                        assert (line_data[8*i +: 8] == want[8*i +: 8]) else begin
                            value_errors++;
                            $display("ERROR: %0t line%0d_char[%0d] expected %h got %h",
                                     $time, lines_checked, i, want[8*i +: 8],
                                     line_data[8*i +: 8]);
                        end
                    end
                end
            end
        end
    end

    // ========================================================
    // Test sequence
    // ========================================================

    initial begin
        rst_n          = 1'b0;
        frame_tick     = 1'b0;
        pixel_valid    = 1'b0;
        cpu            = '0;
        pos            = '0;
        frame_num      = 0;
        pv_acc         = 0;
        lines_expected = 0;
        value_errors   = 0;
        other_errors   = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Quiet pin before any frame_tick
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            drive_cycle(1'b0, 1'b0, 1'b0);
            assert (uart_txd === 1'b1) else begin
                value_errors++;
                $display("ERROR: %0t uart_txd expected 1 got %b", $time, uart_txd);
            end
        end
        assert (byte_count == 0) else begin
            other_errors++;
            $display("Bytes arrived before the first frame_tick");
        end

        // Plain reports
        for (int n = 0; n < 3; n++) begin
            randomize_status(1'b0, 1'b1);
            run_frame(3 + 7 * n, 1'b1);
            wait_lines();
        end

        // Pixel count clips at 9999
        randomize_status(1'b0, 1'b1);
        run_frame(12000, 1'b1);
        wait_lines();

        // Clipped coordinates and a halted CPU
        randomize_status(1'b1, 1'b0);
        run_frame(20, 1'b1);
        wait_lines();

        // Second tick lands while the first line is going out
        randomize_status(1'b0, 1'b1);
        run_frame(4, 1'b1);
        repeat (98) drive_cycle(1'b0, 1'b0, 1'b0);
        randomize_status(1'b0, 1'b0);
        run_frame(0, 1'b0);
        wait_lines();
        randomize_status(1'b0, 1'b1);
        run_frame(9, 1'b1);
        wait_lines();

        assert (exp_q.size() == 0) else begin
            other_errors++;
            $display("Some expected lines never arrived");
        end
        assert (start_errors == 0) else begin
            other_errors++;
            $display("A falling edge on the pin did not hold low for a start bit");
        end
        assert (stop_errors == 0) else begin
            other_errors++;
            $display("Bytes with a bad stop bit were received");
        end

        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Hang guard
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run took longer than the expected line time allows");
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: verilog.f
design/debug_report_pkg.sv
design/uart_tx.sv
design/frame_snapshot.sv
design/report_formatter.sv
design/serial_debug_top.sv
dv/uart_line_monitor.sv
dv/serial_debug_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the serial debug testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module serial_debug_tb \
    -f verilog.f \
    -o serial_debug_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/serial_debug_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench passed" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
